// File: hw/exec_pkg.sv
// shared widths and encodings for the execute stage
// referenced by scoped name from the interfaces and RTL modules
package exec_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  localparam int data_bits     = 32;  // rv32 operand width
  localparam int seq_bits_dflt = 8;   // default tag width
  localparam int reg_addr_bits = 5;   // 32 arch regs

  typedef logic [data_bits-1:0]     data_t;      // operand / result word
  typedef logic [seq_bits_dflt-1:0] seq_num_t;   // instruction tag
  typedef logic [reg_addr_bits-1:0] reg_addr_t;  // dest register

  // --------------------------------------------------
  // micro-ops
  // --------------------------------------------------

  // alu ops in the low codes, multiplies above
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLT   = 4'd5,
    OP_MUL   = 4'd8,   // low half of product
    OP_MULHU = 4'd9    // high half, unsigned x unsigned
  } uop_t;

  // which execute unit takes an op
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_sel_t;

endpackage

// File: hw/d_x_if.sv
// dispatch to execute unit channel, one per unit
// carries the micro-op and operands with a val/rdy handshake
`timescale 1ns/1ps

interface d_x_if #(
  parameter int seq_num_bits = $bits(exec_pkg::seq_num_t)
);

  logic                    val;      // op present
  logic                    rdy;      // unit can take it
  logic [seq_num_bits-1:0] seq_num;  // program-order tag
  exec_pkg::data_t         op1;
  exec_pkg::data_t         op2;
  exec_pkg::reg_addr_t     waddr;    // dest reg
  exec_pkg::uop_t          uop;

  // dispatch side drives the op
  modport dispatch (
    output val, seq_num, op1, op2, waddr, uop,
    input  rdy
  );

  // execute unit side
  modport unit (
    input  val, seq_num, op1, op2, waddr, uop,
    output rdy
  );

endinterface

// File: hw/x_w_if.sv
// execute unit to writeback arbiter channel
// one instance per unit, val/rdy handshake
`timescale 1ns/1ps

interface x_w_if #(
  parameter int seq_num_bits = $bits(exec_pkg::seq_num_t)
);

  logic                    val;      // result present
  logic                    rdy;      // granted and downstream ready
  logic [seq_num_bits-1:0] seq_num;
  exec_pkg::reg_addr_t     waddr;
  exec_pkg::data_t         wdata;

  modport unit (
    output val, seq_num, waddr, wdata,
    input  rdy
  );

  modport wb (
    input  val, seq_num, waddr, wdata,
    output rdy
  );

endinterface

// File: hw/exec_dispatch.sv
// steers each decoded micro-op to the alu or the multiplier
// purely combinational, returns the chosen unit's ready
`timescale 1ns/1ps

module exec_dispatch #(
  parameter int seq_num_bits = $bits(exec_pkg::seq_num_t)
) (
  input  logic                    d_val,
  output logic                    d_rdy,
  input  logic [seq_num_bits-1:0] d_seq_num,
  input  exec_pkg::data_t         d_op1,
  input  exec_pkg::data_t         d_op2,
  input  exec_pkg::reg_addr_t     d_waddr,
  input  exec_pkg::uop_t          d_uop,
  d_x_if.dispatch                 alu,
  d_x_if.dispatch                 mul
);

  exec_pkg::unit_sel_t sel;    // target unit
  logic                known;  // uop is a legal encoding

  // decode uop to unit
  always_comb begin
    sel   = exec_pkg::UNIT_ALU;
    known = 1'b1;
    case (d_uop)
      exec_pkg::OP_ADD, exec_pkg::OP_SUB, exec_pkg::OP_AND,
      exec_pkg::OP_OR, exec_pkg::OP_XOR, exec_pkg::OP_SLT: sel = exec_pkg::UNIT_ALU;
      exec_pkg::OP_MUL, exec_pkg::OP_MULHU:                sel = exec_pkg::UNIT_MUL;
      default:                                             known = 1'b0;  // stall, never drop
    endcase
  end

  // val only to the selected unit
  assign alu.val = d_val & known & (sel == exec_pkg::UNIT_ALU);
  assign mul.val = d_val & known & (sel == exec_pkg::UNIT_MUL);

  // payload fans out to both, val qualifies it
  assign alu.seq_num = d_seq_num;
  assign alu.op1     = d_op1;
  assign alu.op2     = d_op2;
  assign alu.waddr   = d_waddr;
  assign alu.uop     = d_uop;
  assign mul.seq_num = d_seq_num;
  assign mul.op1     = d_op1;
  assign mul.op2     = d_op2;
  assign mul.waddr   = d_waddr;
  assign mul.uop     = d_uop;

  assign d_rdy = known & ((sel == exec_pkg::UNIT_MUL) ? mul.rdy : alu.rdy);

endmodule

// File: hw/alu_unit.sv
// integer alu execute unit
// one input register, result computed combinationally from it
`timescale 1ns/1ps

module alu_unit (
  input  logic clk,
  input  logic rst,
  d_x_if.unit  d,
  x_w_if.unit  w
);

  localparam int seq_num_bits = d.seq_num_bits;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------

  logic                    val_q;
  logic [seq_num_bits-1:0] seq_num_q;
  exec_pkg::data_t         op1_q;
  exec_pkg::data_t         op2_q;
  exec_pkg::reg_addr_t     waddr_q;
  exec_pkg::uop_t          uop_q;

  logic d_xfer;
  logic w_xfer;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = w.val & w.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;   // load wins, covers same-cycle drain and refill
    end else if (w_xfer) begin
      val_q <= 1'b0;
    end
  end

  // payload, loaded only on accept
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      seq_num_q <= d.seq_num;
      op1_q     <= d.op1;
      op2_q     <= d.op2;
      waddr_q   <= d.waddr;
      uop_q     <= d.uop;
    end
  end

  // --------------------------------------------------
  // arithmetic
  // --------------------------------------------------

  always_comb begin
    case (uop_q)
      exec_pkg::OP_ADD: w.wdata = op1_q + op2_q;  // wraps mod 2^32
      exec_pkg::OP_SUB: w.wdata = op1_q - op2_q;
      exec_pkg::OP_AND: w.wdata = op1_q & op2_q;
      exec_pkg::OP_OR:  w.wdata = op1_q | op2_q;
      exec_pkg::OP_XOR: w.wdata = op1_q ^ op2_q;
      exec_pkg::OP_SLT: w.wdata = {31'b0, $signed(op1_q) < $signed(op2_q)};
      default:          w.wdata = '0;  // mul ops never routed here
    endcase
  end

  assign w.val     = val_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign d.rdy     = ~val_q | w.rdy;  // empty, or draining this cycle

endmodule

// File: hw/mul_unit.sv
// multiply execute unit, low and unsigned high halves
// same single input register and handshake as the alu
`timescale 1ns/1ps

module mul_unit (
  input  logic clk,
  input  logic rst,
  d_x_if.unit  d,
  x_w_if.unit  w
);

  localparam int seq_num_bits = d.seq_num_bits;
  localparam int data_bits    = exec_pkg::data_bits;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------

  logic                    val_q;      // register holds an op
  logic [seq_num_bits-1:0] seq_num_q;  // tag of held op
  exec_pkg::data_t         op1_q;
  exec_pkg::data_t         op2_q;
  exec_pkg::reg_addr_t     waddr_q;    // dest of held op
  exec_pkg::uop_t          uop_q;

  logic d_xfer;
  logic w_xfer;

  assign d_xfer = d.val & d.rdy;
  assign w_xfer = w.val & w.rdy;

  // valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;
    end else if (w_xfer) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      seq_num_q <= d.seq_num;
      op1_q     <= d.op1;
      op2_q     <= d.op2;
      waddr_q   <= d.waddr;
      uop_q     <= d.uop;
    end
  end

  // --------------------------------------------------
  // multiply
  // --------------------------------------------------

  logic [2*data_bits-1:0] prod;  // full unsigned product

  assign prod = {{data_bits{1'b0}}, op1_q} * {{data_bits{1'b0}}, op2_q};

  always_comb begin
    case (uop_q)
      exec_pkg::OP_MUL:   w.wdata = prod[data_bits-1:0];
      exec_pkg::OP_MULHU: w.wdata = prod[2*data_bits-1:data_bits];
      default:            w.wdata = '0;  // alu ops never land here
    endcase
  end

  assign w.val     = val_q;
  assign w.seq_num = seq_num_q;
  assign w.waddr   = waddr_q;
  assign d.rdy     = ~val_q | w.rdy;

endmodule

// File: hw/wb_arbiter.sv
// round-robin merge of the two execute units onto one writeback port
// zero latency, grant held steady while the port is stalled
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int seq_num_bits = $bits(exec_pkg::seq_num_t)
) (
  input  logic                    clk,
  input  logic                    rst,
  x_w_if.wb                       alu,
  x_w_if.wb                       mul,
  output logic                    w_val,
  input  logic                    w_rdy,
  output logic [seq_num_bits-1:0] w_seq_num,
  output exec_pkg::reg_addr_t     w_waddr,
  output exec_pkg::data_t         w_wdata
);

  exec_pkg::unit_sel_t last_q;  // winner of last transfer
  exec_pkg::unit_sel_t hold_sel_q;
  logic                hold_q;  // stalled last cycle, keep grant
  exec_pkg::unit_sel_t grant;

  // --------------------------------------------------
  // grant
  // --------------------------------------------------

  always_comb begin
    if (hold_q) begin
      grant = hold_sel_q;  // stalled unit still valid, keep it on the port
    end else if (alu.val & mul.val) begin
      grant = (last_q == exec_pkg::UNIT_ALU) ? exec_pkg::UNIT_MUL : exec_pkg::UNIT_ALU;
    end else if (mul.val) begin
      grant = exec_pkg::UNIT_MUL;
    end else begin
      grant = exec_pkg::UNIT_ALU;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= exec_pkg::UNIT_MUL;  // alu favoured first
      hold_q <= 1'b0;
    end else begin
      if (w_val & w_rdy)
        last_q <= grant;
      hold_q <= w_val & ~w_rdy;
    end
  end

  always_ff @(posedge clk) begin
    hold_sel_q <= grant;
  end

  // --------------------------------------------------
  // payload mux and ready return
  // --------------------------------------------------

  assign w_val     = (grant == exec_pkg::UNIT_MUL) ? mul.val     : alu.val;
  assign w_seq_num = (grant == exec_pkg::UNIT_MUL) ? mul.seq_num : alu.seq_num;
  assign w_waddr   = (grant == exec_pkg::UNIT_MUL) ? mul.waddr   : alu.waddr;
  assign w_wdata   = (grant == exec_pkg::UNIT_MUL) ? mul.wdata   : alu.wdata;

  assign alu.rdy = w_rdy & (grant == exec_pkg::UNIT_ALU);
  assign mul.rdy = w_rdy & (grant == exec_pkg::UNIT_MUL);

endmodule

// File: hw/exec_stage.sv
// execute stage top, plain decode and writeback ports
// dispatch -> alu / mul -> round-robin writeback
`timescale 1ns/1ps

module exec_stage #(
  parameter int seq_num_bits = $bits(exec_pkg::seq_num_t)
) (
  input  logic                    clk,
  input  logic                    rst,

  // from decode
  input  logic                    d_val,
  output logic                    d_rdy,
  input  logic [seq_num_bits-1:0] d_seq_num,
  input  exec_pkg::data_t         d_op1,
  input  exec_pkg::data_t         d_op2,
  input  exec_pkg::reg_addr_t     d_waddr,
  input  exec_pkg::uop_t          d_uop,

  // to writeback
  output logic                    w_val,
  input  logic                    w_rdy,
  output logic [seq_num_bits-1:0] w_seq_num,
  output exec_pkg::reg_addr_t     w_waddr,
  output exec_pkg::data_t         w_wdata
);

  // --------------------------------------------------
  // unit channels
  // --------------------------------------------------

  d_x_if #(.seq_num_bits(seq_num_bits)) d_alu ();
  d_x_if #(.seq_num_bits(seq_num_bits)) d_mul ();
  x_w_if #(.seq_num_bits(seq_num_bits)) w_alu ();
  x_w_if #(.seq_num_bits(seq_num_bits)) w_mul ();

  exec_dispatch #(.seq_num_bits(seq_num_bits)) dispatch (
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .alu       (d_alu.dispatch),
    .mul       (d_mul.dispatch)
  );

  alu_unit alu (.clk(clk), .rst(rst), .d(d_alu.unit), .w(w_alu.unit));
  mul_unit mul (.clk(clk), .rst(rst), .d(d_mul.unit), .w(w_mul.unit));

  wb_arbiter #(.seq_num_bits(seq_num_bits)) arb (
    .clk       (clk),
    .rst       (rst),
    .alu       (w_alu.wb),
    .mul       (w_mul.wb),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata)
  );

endmodule

// File: dv/exec_stage_assertions.sv
// writeback handshake checks for the execute stage
// attached to every exec_stage instance by the bind below
`timescale 1ns/1ps

module exec_stage_assertions #(
  parameter int seq_num_bits = 8
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    d_val,
  input logic                    w_val,
  input logic                    w_rdy,
  input logic [seq_num_bits-1:0] w_seq_num,
  input exec_pkg::reg_addr_t     w_waddr,
  input exec_pkg::data_t         w_wdata
);

  // quiet ports while reset is held
  reset_idle: assert property (@(posedge clk) rst && $past(rst) |-> !w_val && !d_val)
    else $error("valid high during reset");

  // stalled writeback holds val and payload
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_seq_num) && $stable(w_waddr) && $stable(w_wdata))
    else $error("writeback changed while stalled");

  tag_known: assert property (@(posedge clk) disable iff (rst)
    w_val |-> !$isunknown(w_seq_num))
    else $error("writeback tag unknown while valid");

endmodule

bind exec_stage exec_stage_assertions #(.seq_num_bits(seq_num_bits)) assertions (
  .clk       (clk),
  .rst       (rst),
  .d_val     (d_val),
  .w_val     (w_val),
  .w_rdy     (w_rdy),
  .w_seq_num (w_seq_num),
  .w_waddr   (w_waddr),
  .w_wdata   (w_wdata)
);

// File: dv/exec_stage_tb.sv
// directed testbench for the execute stage
// scoreboard keyed by seq_num, results may leave out of order
`timescale 1ns/1ps

module exec_stage_tb;

  localparam int n_ops         = 133;             // ops issued over all tests
  localparam int timeout_limit = 4 * n_ops + 200;  // cycles

  logic                clk = 1'b0;
  logic                rst;
  logic                d_val;
  logic                d_rdy;
  logic [7:0]          d_seq_num;
  exec_pkg::data_t     d_op1;
  exec_pkg::data_t     d_op2;
  exec_pkg::reg_addr_t d_waddr;
  exec_pkg::uop_t      d_uop;
  logic                w_val;
  logic                w_rdy = 1'b1;
  logic [7:0]          w_seq_num;
  exec_pkg::reg_addr_t w_waddr;
  exec_pkg::data_t     w_wdata;

  exec_pkg::data_t     exp_data [int];  // expected result by seq_num
  exec_pkg::reg_addr_t exp_addr [int];
  logic [7:0]          seq = 8'd0;      // next tag to issue
  string               cur_test = "reset";
  int                  cycles = 0;
  int                  xfer_prev = 0;   // cycle of the writeback before last
  int                  xfer_last = 0;
  logic                bp_on = 1'b0;    // random back-pressure
  logic                rdy_level = 1'b1;

  exec_stage #(.seq_num_bits(8)) DUT (.*);

  always #20 clk = ~clk;

  // w_rdy owned here, changes on the falling edge only
  always @(negedge clk) w_rdy = bp_on ? (($urandom & 32'd3) != 0) : rdy_level;

  // --------------------------------------------------
  // failure reporting and compare
  // --------------------------------------------------

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  // expected result straight from the op definitions
  function automatic exec_pkg::data_t model(exec_pkg::uop_t u, exec_pkg::data_t a,
                                            exec_pkg::data_t b);
    logic [63:0] p;
    p = 64'd0;
    for (int i = 0; i < 32; i++) begin
      if (b[i])
        p = p + (64'(a) << i);  // shift-and-add, unsigned
    end
    case (u)
      exec_pkg::OP_ADD:   return a + b;
      exec_pkg::OP_SUB:   return a - b;
      exec_pkg::OP_AND:   return a & b;
      exec_pkg::OP_OR:    return a | b;
      exec_pkg::OP_XOR:   return a ^ b;
      exec_pkg::OP_SLT:   return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};  // signs differ
      exec_pkg::OP_MUL:   return p[31:0];
      exec_pkg::OP_MULHU: return p[63:32];
      default:            return '0;
    endcase
  endfunction

  // writeback monitor, timeout and transfer timestamps
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_limit)
      fail_run("timeout, ops still waiting for handshake or writeback");
    if (!rst && w_val && w_rdy) begin
      if ($isunknown(w_seq_num)) begin
        fail_run("writeback with an unknown sequence number");
      end else if (!exp_data.exists(int'(w_seq_num))) begin
        fail_run($sformatf("writeback of seq %0d that is not outstanding", w_seq_num));
      end else begin
        check("wdata", exp_data[int'(w_seq_num)], w_wdata);
        check("waddr", 32'(exp_addr[int'(w_seq_num)]), 32'(w_waddr));
        exp_data.delete(int'(w_seq_num));
        exp_addr.delete(int'(w_seq_num));
        xfer_prev = xfer_last;
        xfer_last = cycles;
      end
    end
  end

  // --------------------------------------------------
  // drivers
  // --------------------------------------------------

  // one op, returns at the edge it is accepted
  task automatic issue(exec_pkg::uop_t u, exec_pkg::data_t a, exec_pkg::data_t b);
    exec_pkg::reg_addr_t wa;
    wa = exec_pkg::reg_addr_t'($urandom);
    exp_data[int'(seq)] = model(u, a, b);
    exp_addr[int'(seq)] = wa;
    @(negedge clk);
    d_val     = 1'b1;
    d_seq_num = seq;
    d_op1     = a;
    d_op2     = b;
    d_waddr   = wa;
    d_uop     = u;
    @(posedge clk);
    while (!d_rdy) @(posedge clk);
    seq = seq + 8'd1;
  endtask

  task automatic idle();
    @(negedge clk);
    d_val = 1'b0;
  endtask

  task automatic drain();
    while (exp_data.num() != 0) @(posedge clk);
  endtask

  function automatic exec_pkg::uop_t pick_op(bit to_mul);
    int k;
    k = int'($urandom_range(0, 5));
    if (to_mul) return k[0] ? exec_pkg::OP_MULHU : exec_pkg::OP_MUL;
    case (k)
      0:       return exec_pkg::OP_ADD;
      1:       return exec_pkg::OP_SUB;
      2:       return exec_pkg::OP_AND;
      3:       return exec_pkg::OP_OR;
      4:       return exec_pkg::OP_XOR;
      default: return exec_pkg::OP_SLT;
    endcase
  endfunction

  // --------------------------------------------------
  // tests
  // --------------------------------------------------

  task automatic test_reset();
    cur_test = "reset";
    repeat (4) begin
      @(posedge clk);
      check("w_val idle", 32'd0, 32'(w_val));
    end
    issue(exec_pkg::OP_ADD, 32'd5, 32'd7);
    idle();
    @(posedge clk);
    check("w_val after accept", 32'd1, 32'(w_val));  // cycle right after accept
    drain();
  endtask

  task automatic test_alu_edges();
    exec_pkg::uop_t  ops [$] = '{exec_pkg::OP_ADD, exec_pkg::OP_SUB, exec_pkg::OP_AND,
                                 exec_pkg::OP_OR, exec_pkg::OP_XOR, exec_pkg::OP_SLT};
    exec_pkg::data_t ea [$] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                                32'h1234_5678};
    exec_pkg::data_t eb [$] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h1234_5678};
    cur_test = "alu_edges";
    foreach (ops[i])
      foreach (ea[j])
        issue(ops[i], ea[j], eb[j]);
    idle();
    drain();
  endtask

  task automatic test_mul();
    exec_pkg::data_t ea [$] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
    exec_pkg::data_t eb [$] = '{32'hffff_ffff, 32'hffff_ffff, 32'h2, 32'h1};
    cur_test = "mul";
    foreach (ea[j]) begin
      issue(exec_pkg::OP_MUL, ea[j], eb[j]);
      issue(exec_pkg::OP_MULHU, ea[j], eb[j]);
    end
    repeat (6) begin
      issue(exec_pkg::OP_MUL, $urandom, $urandom);
      issue(exec_pkg::OP_MULHU, $urandom, $urandom);
    end
    idle();
    drain();
  endtask

  // alternating units, optional random stall on writeback
  task automatic test_stream(string name, logic stall);
    cur_test = name;
    bp_on    = stall;
    for (int i = 0; i < 40; i++)
      issue(pick_op(i[0]), $urandom, $urandom);
    idle();
    drain();
    bp_on = 1'b0;
  endtask

  // both units loaded behind a stalled port, then released together
  task automatic test_fairness();
    cur_test  = "fairness";
    rdy_level = 1'b0;
    issue(exec_pkg::OP_XOR, 32'hdead_beef, 32'h0f0f_0f0f);
    issue(exec_pkg::OP_MUL, 32'h0001_0003, 32'h0002_0005);
    idle();
    repeat (3) @(posedge clk);
    check("d_rdy with mul unit full", 32'd0, 32'(d_rdy));  // d_uop still selects mul
    rdy_level = 1'b1;
    drain();
    check("cycles between the two writebacks", 32'd1, 32'(xfer_last - xfer_prev));
  endtask

  initial begin
    void'($urandom(32'h4982_a96d));
    rst       = 1'b1;
    d_val     = 1'b0;
    d_seq_num = 8'd0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    d_uop     = exec_pkg::OP_ADD;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_alu_edges();
    test_mul();
    test_stream("mixed", 1'b0);
    test_stream("backpressure", 1'b1);
    test_fairness();
    if (exp_data.num() != 0) begin
      fail_run("results still outstanding at the end of the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: flist.f
hw/exec_pkg.sv
hw/d_x_if.sv
hw/x_w_if.sv
hw/exec_dispatch.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/wb_arbiter.sv
hw/exec_stage.sv
dv/exec_stage_assertions.sv
dv/exec_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator, fail if the log reports failure
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -f flist.f --top-module exec_stage_tb &&
{ ./obj_dir/Vexec_stage_tb > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Result: FAILED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
